// File: compile.f
uart_str_pkg.sv
uart_tx.sv
uart_rx.sv
str_framer.sv
str_deframer.sv
uart_string_top.sv
tb_uart_string.sv

// File: Makefile
# Verilator build and run of the framed string link testbench.
SIM  := obj_dir/Vtb_uart_string
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_string \
		-f compile.f -o Vtb_uart_string

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'All checks passed'

clean:
	rm -rf obj_dir

// File: tb_uart_string.sv
`timescale 1ns/1ps
/*
 * Testbench for the framed string link. Loopback and direct line drive,
 * a reference deframer over the byte stream on the receive line, and a
 * monitor that compares every delivery and error pulse.
 */
module tb_uart_string;

	localparam int MAX_LEN = 16;
	localparam int LEN_W   = $clog2(MAX_LEN + 1);
	localparam int SW      = MAX_LEN * 8;
	localparam int TIMEOUT = 4000;                  // Clock cycles per wait.

	logic             sys_clk;
	logic             sys_rst_n;
	logic [SW-1:0]    tx_string;
	logic [LEN_W-1:0] tx_length;
	logic             tx_valid;
	logic             tx_ready;
	logic             tx_done;
	logic [SW-1:0]    rx_string;
	logic [LEN_W-1:0] rx_length;
	logic             rx_valid;
	logic             rx_error;
	logic             uart_rx_port;
	logic             uart_tx_port;
	logic             loopback;                     // Receiver listens to uart_tx_port.
	logic             drv_line;

	logic [7:0]    byte_q[$];                       // Bytes put on the receive line.
	logic [7:0]    ref_buf[$];
	logic          ref_prev_mark;
	int            exp_kind[$];                     // 0 for a string and 1 for an error pulse.
	logic [SW-1:0] exp_str[$];
	int            exp_len[$];
	int            checks = 0;
	int            errors = 0;
	int            tests = 0;
	int            test_base = 0;
	int            valid_cnt = 0;
	int            error_cnt = 0;
	int            done_cnt = 0;

	uart_str_pkg::deframer_state_e ref_state;

	assign uart_rx_port = loopback ? uart_tx_port : drv_line;

	uart_string_top #(
		.BAUD_RATE    (2_500_000),
		.MAX_LEN      (MAX_LEN)
	) u_uart_string_top (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_valid     (tx_valid),
		.tx_ready     (tx_ready),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_valid     (rx_valid),
		.rx_error     (rx_error),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	function automatic void check_value(string name, logic [SW-1:0] got, logic [SW-1:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
		end
	endfunction

	function automatic void check_true(logic cond, string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("ERROR at %0t: %s", $time, what);
		end
	endfunction

	function automatic logic [SW-1:0] pack_bytes(logic [7:0] b[$]);
		logic [SW-1:0] v;
		v = '0;                                     // Zeros above the length.
		for (int i = 0; i < b.size(); i++)
			v[i*8 +: 8] = b[i];
		return v;
	endfunction

	function automatic logic [SW-1:0] pack_text(string s);
		logic [SW-1:0] v;
		v = '0;
		for (int i = 0; i < s.len(); i++)
			v[i*8 +: 8] = s[i];
		return v;
	endfunction

	function automatic void enter_drop();
		exp_kind.push_back(1);
		ref_prev_mark = 1'b0;
		ref_state     = uart_str_pkg::df_drop;
	endfunction

	// Reference deframer over every byte queued for the receiver.
	function automatic void reference_deframe();
		logic [7:0] b;
		logic       m;
		while (byte_q.size() > 0) begin
			b = byte_q.pop_front();
			m = (b == uart_str_pkg::frame_mark);
			case (ref_state)
			uart_str_pkg::df_hunt: begin
				if (m)
					ref_state = uart_str_pkg::df_head2;
			end
			uart_str_pkg::df_head2: begin
				ref_buf.delete();
				ref_state = m ? uart_str_pkg::df_body : uart_str_pkg::df_hunt;
			end
			uart_str_pkg::df_body: begin
				if (m)
					ref_state = uart_str_pkg::df_mark;
				else if (ref_buf.size() < MAX_LEN)
					ref_buf.push_back(b);
				else
					enter_drop();
			end
			uart_str_pkg::df_mark: begin
				if (m) begin
					if (ref_buf.size() > 0) begin       // Four marks give nothing.
						exp_kind.push_back(0);
						exp_str.push_back(pack_bytes(ref_buf));
						exp_len.push_back(ref_buf.size());
					end
					ref_state = uart_str_pkg::df_hunt;
				end else if (ref_buf.size() + 2 <= MAX_LEN) begin
					ref_buf.push_back(uart_str_pkg::frame_mark);
					ref_buf.push_back(b);
					ref_state = uart_str_pkg::df_body;
				end else begin
					enter_drop();
				end
			end
			default: begin
				if (m && ref_prev_mark)
					ref_state = uart_str_pkg::df_hunt;
				ref_prev_mark = m && !ref_prev_mark;
			end
			endcase
		end
	endfunction

	// Monitor that compares each delivery against the reference.
	always @(negedge sys_clk) begin : monitor
		logic [SW-1:0] want_str;
		int            want_len;
		if (sys_rst_n) begin
			if (tx_done)
				done_cnt++;
			if (rx_error) begin
				error_cnt++;
				check_true(exp_kind.size() > 0 && exp_kind[0] == 1,
					"rx_error pulsed without an oversized frame");
				if (exp_kind.size() > 0 && exp_kind[0] == 1)
					void'(exp_kind.pop_front());
			end
			if (rx_valid) begin
				valid_cnt++;
				check_true(exp_kind.size() > 0 && exp_kind[0] == 0,
					"rx_valid pulsed with no frame expected");
				if (exp_kind.size() > 0 && exp_kind[0] == 0) begin
					void'(exp_kind.pop_front());
					want_str = exp_str.pop_front();
					want_len = exp_len.pop_front();
					check_value("rx_string", rx_string, want_str);
					check_value("rx_length", SW'(rx_length), SW'(want_len));
				end
			end
		end
	end

	// Hands one string to the framer and waits for the frame to leave.
	task automatic send_string(logic [SW-1:0] str, int len);
		int cycles;
		@(posedge sys_clk);
		#2;
		tx_string = str;
		tx_length = LEN_W'(len);
		tx_valid  = 1'b1;
		cycles    = 0;
		@(negedge sys_clk);
		while (!tx_ready && cycles < TIMEOUT) begin
			@(negedge sys_clk);
			cycles++;
		end
		check_true(tx_ready, "timeout waiting for tx_ready");
		@(posedge sys_clk);
		#2;
		tx_valid = 1'b0;
		byte_q.push_back(uart_str_pkg::frame_mark);
		byte_q.push_back(uart_str_pkg::frame_mark);
		for (int i = 0; i < len; i++)
			byte_q.push_back(str[i*8 +: 8]);
		byte_q.push_back(uart_str_pkg::frame_mark);
		byte_q.push_back(uart_str_pkg::frame_mark);
		reference_deframe();
		cycles = 0;
		@(negedge sys_clk);
		while (!tx_done && cycles < TIMEOUT) begin
			@(negedge sys_clk);
			cycles++;
		end
		check_true(tx_done, "timeout waiting for tx_done");
		@(negedge sys_clk);
		check_value("tx_ready", SW'(tx_ready), SW'(1));
		check_value("tx_done", SW'(tx_done), SW'(0));
	endtask

	// Line driver with 10 clocks per bit and one stop bit.
	task automatic drive_byte(logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		byte_q.push_back(b);
		reference_deframe();
		for (int i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			#2;
			drv_line = frame[i];
			repeat (9) @(posedge sys_clk);
		end
	endtask

	task automatic drive_text(string s);
		for (int i = 0; i < s.len(); i++)
			drive_byte(s[i]);
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_kind.size() > 0 && cycles < TIMEOUT) begin
			@(negedge sys_clk);
			cycles++;
		end
		check_true(exp_kind.size() == 0, "expected frames or errors never arrived");
		@(posedge sys_clk);
	endtask

	function automatic void end_test(string name);
		tests++;
		$display("Test %0d %s: %0d errors", tests, name, errors - test_base);
		test_base = errors;
	endfunction

	initial begin
		logic [SW-1:0] str;
		logic [7:0]    b;
		logic [7:0]    prev;
		int            len;
		int            v0;
		int            e0;
		int            d0;
		void'($urandom(32'h0605_583c));
		sys_rst_n     = 1'b0;
		tx_string     = '0;
		tx_length     = '0;
		tx_valid      = 1'b0;
		loopback      = 1'b1;
		drv_line      = 1'b1;
		ref_state     = uart_str_pkg::df_hunt;
		ref_prev_mark = 1'b0;
		repeat (3) @(posedge sys_clk);
		#2;
		sys_rst_n = 1'b1;

		@(negedge sys_clk);
		check_value("uart_tx_port", SW'(uart_tx_port), SW'(1));
		check_value("tx_ready", SW'(tx_ready), SW'(1));
		check_value("tx_done", SW'(tx_done), SW'(0));
		check_value("rx_valid", SW'(rx_valid), SW'(0));
		check_value("rx_error", SW'(rx_error), SW'(0));
		check_value("rx_string", rx_string, '0);
		check_value("rx_length", SW'(rx_length), SW'(0));
		end_test("reset values");

		v0 = valid_cnt;
		d0 = done_cnt;
		send_string(pack_text("A"), 1);
		send_string(pack_text("ab&cd"), 5);
		send_string(pack_text("0123456789abcdef"), 16);
		wait_drain();
		check_value("tx_done count", SW'(done_cnt - d0), SW'(3));
		check_value("rx_valid count", SW'(valid_cnt - v0), SW'(3));
		end_test("loopback fixed strings");

		v0 = valid_cnt;
		for (int n = 0; n < 20; n++) begin
			len  = 1 + int'($urandom % MAX_LEN);
			str  = '0;
			prev = 8'h00;
			for (int i = 0; i < len; i++) begin
				b = 8'($urandom);
				// Keep the payload legal for the framing.
				if (b == uart_str_pkg::frame_mark && (prev == b || i == len - 1))
					b = 8'h5a;
				str[i*8 +: 8] = b;
				prev          = b;
			end
			send_string(str, len);
		end
		wait_drain();
		check_value("rx_valid count", SW'(valid_cnt - v0), SW'(20));
		end_test("loopback random strings");

		loopback = 1'b0;
		v0 = valid_cnt;
		e0 = error_cnt;
		drive_text("zq");
		drive_text("&q");
		drive_text("&&&&");
		drive_text("&&ok&&");
		wait_drain();
		check_value("rx_valid count", SW'(valid_cnt - v0), SW'(1));
		check_value("rx_error count", SW'(error_cnt - e0), SW'(0));
		end_test("line noise");

		v0 = valid_cnt;
		e0 = error_cnt;
		drive_text("&&ABCDEFGHIJKLMNOPQ&&");
		drive_text("&&fine&&");
		wait_drain();
		check_value("rx_valid count", SW'(valid_cnt - v0), SW'(1));
		check_value("rx_error count", SW'(error_cnt - e0), SW'(1));
		end_test("oversized frame");

		repeat (40) @(posedge sys_clk);          // Room for any stray pulse.
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: uart_string_top.sv
`timescale 1ns/1ps
/*
 * Top level of the framed string link. Derives the bit period and
 * connects framer -> uart_tx and uart_rx -> deframer.
 */
module uart_string_top #(
	parameter int  CLK_HZ    = 25_000_000,
	parameter int  BAUD_RATE = 115_200,
	parameter int  MAX_LEN   = 16,
	localparam int LEN_W     = $clog2(MAX_LEN + 1)
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic [MAX_LEN*8-1:0] tx_string,
	input  logic [LEN_W-1:0]     tx_length,
	input  logic                 tx_valid,
	output logic                 tx_ready,
	output logic                 tx_done,
	output logic [MAX_LEN*8-1:0] rx_string,
	output logic [LEN_W-1:0]     rx_length,
	output logic                 rx_valid,
	output logic                 rx_error,
	input  logic                 uart_rx_port,
	output logic                 uart_tx_port
);

	// Clocks per bit rounded to nearest.
	localparam int BIT_CLKS = (CLK_HZ + BAUD_RATE / 2) / BAUD_RATE;

	logic [7:0] byte_data;
	logic       byte_valid;
	logic       byte_ready;
	logic [7:0] rx_byte;
	logic       rx_byte_valid;

	str_framer #(
		.MAX_LEN    (MAX_LEN)
	) u_str_framer (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_string  (tx_string),
		.tx_length  (tx_length),
		.tx_valid   (tx_valid),
		.tx_ready   (tx_ready),
		.tx_done    (tx_done),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.byte_ready (byte_ready)
	);

	uart_tx #(
		.BIT_CLKS     (BIT_CLKS),
		.STOP_BITS    (2)
	) u_uart_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.byte_data    (byte_data),
		.byte_valid   (byte_valid),
		.byte_ready   (byte_ready),
		.uart_tx_port (uart_tx_port)
	);

	uart_rx #(
		.BIT_CLKS      (BIT_CLKS)
	) u_uart_rx (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.uart_rx_port  (uart_rx_port),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid)
	);

	str_deframer #(
		.MAX_LEN       (MAX_LEN)
	) u_str_deframer (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid),
		.rx_string     (rx_string),
		.rx_length     (rx_length),
		.rx_valid      (rx_valid),
		.rx_error      (rx_error)
	);

endmodule

// File: str_deframer.sv
`timescale 1ns/1ps
/*
 * String deframer. Hunts for "&&", collects the payload up to the
 * closing "&&" and delivers it with a one-cycle valid; oversized
 * frames are dropped with a one-cycle error.
 */
module str_deframer #(
	parameter int  MAX_LEN = 16,
	localparam int LEN_W   = $clog2(MAX_LEN + 1)
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic [7:0]           rx_byte,
	input  logic                 rx_byte_valid,
	output logic [MAX_LEN*8-1:0] rx_string,
	output logic [LEN_W-1:0]     rx_length,
	output logic                 rx_valid,
	output logic                 rx_error
);

	uart_str_pkg::deframer_state_e state;
	logic [MAX_LEN*8-1:0]          work_buf;
	logic [LEN_W-1:0]              work_len;
	logic                          drop_mark;   // Previous byte in drop was a mark.
	logic                          is_mark;
	logic                          room_one;
	logic                          room_two;
	logic                          frame_open;
	logic                          store_one;
	logic                          store_two;
	logic                          close_frame;
	logic                          overflow;

	assign is_mark  = (rx_byte == uart_str_pkg::frame_mark);
	assign room_one = (work_len < MAX_LEN);
	assign room_two = (work_len + 2 <= MAX_LEN);

	assign frame_open  = rx_byte_valid && is_mark && (state == uart_str_pkg::df_head2);
	assign store_one   = rx_byte_valid && !is_mark && (state == uart_str_pkg::df_body) && room_one;
	// Lone mark plus the byte after it.
	assign store_two   = rx_byte_valid && !is_mark && (state == uart_str_pkg::df_mark) && room_two;
	assign close_frame = rx_byte_valid && is_mark && (state == uart_str_pkg::df_mark);
	assign overflow    = rx_byte_valid && !is_mark &&
		(((state == uart_str_pkg::df_body) && !room_one) ||
		 ((state == uart_str_pkg::df_mark) && !room_two));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= uart_str_pkg::df_hunt;
			work_len  <= '0;
			drop_mark <= 1'b0;
			rx_string <= '0;
			rx_length <= '0;
			rx_valid  <= 1'b0;
			rx_error  <= 1'b0;
		end else begin
			rx_valid <= close_frame && (work_len != '0);   // Empty frame is discarded.
			rx_error <= overflow;
			if (frame_open)
				work_len <= '0;
			else if (store_one)
				work_len <= work_len + LEN_W'(1);
			else if (store_two)
				work_len <= work_len + LEN_W'(2);
			if (close_frame && work_len != '0) begin
				rx_string <= work_buf;
				rx_length <= work_len;
			end
			if (rx_byte_valid) begin
				case (state)
				uart_str_pkg::df_hunt: begin
					if (is_mark)
						state <= uart_str_pkg::df_head2;
				end
				uart_str_pkg::df_head2: begin
					state <= is_mark ? uart_str_pkg::df_body : uart_str_pkg::df_hunt;
				end
				uart_str_pkg::df_body, uart_str_pkg::df_mark: begin
					drop_mark <= 1'b0;
					if (overflow)
						state <= uart_str_pkg::df_drop;
					else if (close_frame)
						state <= uart_str_pkg::df_hunt;
					else if (is_mark)
						state <= uart_str_pkg::df_mark;
					else
						state <= uart_str_pkg::df_body;
				end
				uart_str_pkg::df_drop: begin
					// Two marks in a row end the dropped frame.
					if (is_mark && drop_mark)
						state <= uart_str_pkg::df_hunt;
					drop_mark <= is_mark && !drop_mark;
				end
				default: state <= uart_str_pkg::df_hunt;
				endcase
			end
		end
	end

	// Working buffer is zeroed at frame start so unused bytes read as zero.
	always_ff @(posedge sys_clk) begin
		if (frame_open)
			work_buf <= '0;
		else if (store_one)
			work_buf[work_len*8 +: 8] <= rx_byte;
		else if (store_two)
			work_buf[work_len*8 +: 16] <= {rx_byte, uart_str_pkg::frame_mark};
	end

	a_len_delivered: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_valid |-> (rx_length >= 1 && rx_length <= MAX_LEN));

endmodule

// File: str_framer.sv
`timescale 1ns/1ps
/*
 * String framer. Accepts a string on the tx handshake and offers
 * "&&", the payload bytes and "&&" to the UART transmitter one at a time.
 */
module str_framer #(
	parameter int  MAX_LEN = 16,
	localparam int LEN_W   = $clog2(MAX_LEN + 1)
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic [MAX_LEN*8-1:0] tx_string,
	input  logic [LEN_W-1:0]     tx_length,
	input  logic                 tx_valid,
	output logic                 tx_ready,
	output logic                 tx_done,
	output logic [7:0]           byte_data,
	output logic                 byte_valid,
	input  logic                 byte_ready
);

	uart_str_pkg::framer_state_e state;
	logic [MAX_LEN*8-1:0]        str_buf;     // Payload with byte 0 at the bottom.
	logic [LEN_W-1:0]            bytes_left;
	logic                        tail_sent;   // Last mark handed to uart_tx.
	logic                        accept;
	logic                        byte_fire;

	assign tx_ready   = (state == uart_str_pkg::fr_idle);
	assign accept     = tx_valid && tx_ready;
	assign byte_valid = (state != uart_str_pkg::fr_idle) && !tail_sent;
	assign byte_fire  = byte_valid && byte_ready;
	assign byte_data  = (state == uart_str_pkg::fr_body) ? str_buf[7:0] : uart_str_pkg::frame_mark;

	// Transmitter back to idle after the final mark.
	assign tx_done = (state == uart_str_pkg::fr_tail2) && tail_sent && byte_ready;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= uart_str_pkg::fr_idle;
			bytes_left <= '0;
			tail_sent  <= 1'b0;
		end else begin
			case (state)
			uart_str_pkg::fr_idle: begin
				tail_sent <= 1'b0;
				if (accept) begin
					state      <= uart_str_pkg::fr_head1;
					bytes_left <= tx_length;
				end
			end
			uart_str_pkg::fr_head1: begin
				if (byte_fire)
					state <= uart_str_pkg::fr_head2;
			end
			uart_str_pkg::fr_head2: begin
				if (byte_fire)
					state <= uart_str_pkg::fr_body;
			end
			uart_str_pkg::fr_body: begin
				if (byte_fire) begin
					bytes_left <= bytes_left - LEN_W'(1);
					if (bytes_left == LEN_W'(1))
						state <= uart_str_pkg::fr_tail1;
				end
			end
			uart_str_pkg::fr_tail1: begin
				if (byte_fire)
					state <= uart_str_pkg::fr_tail2;
			end
			uart_str_pkg::fr_tail2: begin
				if (tx_done) begin
					state     <= uart_str_pkg::fr_idle;
					tail_sent <= 1'b0;
				end else if (byte_fire) begin
					tail_sent <= 1'b1;
				end
			end
			default: state <= uart_str_pkg::fr_idle;
			endcase
		end
	end

	// Payload shifts down one byte per body transfer.
	always_ff @(posedge sys_clk) begin
		if (accept)
			str_buf <= tx_string;
		else if (state == uart_str_pkg::fr_body && byte_fire)
			str_buf <= str_buf >> 8;
	end

	a_len_legal: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		accept |-> (tx_length >= 1 && tx_length <= MAX_LEN));

endmodule

// File: uart_rx.sv
`timescale 1ns/1ps
/*
 * UART receiver. Two-flop line synchronizer, falling-edge start detect
 * and mid-bit sampling; emits a one-cycle strobe per good byte.
 */
module uart_rx #(
	parameter int BIT_CLKS = 217
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       uart_rx_port,
	output logic [7:0] rx_byte,
	output logic       rx_byte_valid
);

	localparam int CNT_W = $clog2(BIT_CLKS + 1);
	localparam int HALF  = (BIT_CLKS - 1) / 2;

	uart_str_pkg::uart_state_e state;
	logic [1:0]                rx_sync;
	logic                      rx_line;
	logic                      rx_prev;
	logic                      falling;
	logic [CNT_W-1:0]          bit_cnt;
	logic [2:0]                bit_idx;
	logic [7:0]                rx_shift;
	logic                      bit_end;
	logic                      data_sample;
	logic                      stop_ok;

	assign rx_line     = rx_sync[1];
	assign falling     = rx_prev && !rx_line;
	assign bit_end     = (bit_cnt == CNT_W'(BIT_CLKS - 1));
	assign data_sample = (state == uart_str_pkg::uart_data) && bit_end;
	assign stop_ok     = (state == uart_str_pkg::uart_stop) && bit_end && rx_line;

	// Synchronizer and edge history reset high.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
		end else begin
			rx_sync <= {rx_sync[0], uart_rx_port};
			rx_prev <= rx_line;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state         <= uart_str_pkg::uart_idle;
			bit_cnt       <= '0;
			bit_idx       <= '0;
			rx_byte_valid <= 1'b0;
		end else begin
			rx_byte_valid <= stop_ok;
			bit_cnt       <= bit_end ? '0 : bit_cnt + CNT_W'(1);
			case (state)
			uart_str_pkg::uart_idle: begin
				bit_cnt <= '0;
				if (falling)
					state <= uart_str_pkg::uart_start;
			end
			uart_str_pkg::uart_start: begin
				if (bit_cnt == CNT_W'(HALF)) begin      // Middle of the start bit.
					bit_cnt <= '0;
					bit_idx <= '0;
					state   <= rx_line ? uart_str_pkg::uart_idle : uart_str_pkg::uart_data;
				end
			end
			uart_str_pkg::uart_data: begin
				if (bit_end) begin
					bit_idx <= bit_idx + 3'd1;
					if (bit_idx == 3'd7)
						state <= uart_str_pkg::uart_stop;
				end
			end
			uart_str_pkg::uart_stop: begin
				if (bit_end)
					state <= uart_str_pkg::uart_idle;   // Bad stop bit just drops the byte.
			end
			default: state <= uart_str_pkg::uart_idle;
			endcase
		end
	end

	// Deserializer with the LSB first.
	always_ff @(posedge sys_clk) begin
		if (data_sample)
			rx_shift <= {rx_line, rx_shift[7:1]};
		if (stop_ok)
			rx_byte <= rx_shift;
	end

	a_valid_single_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_byte_valid |=> !rx_byte_valid);

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps
/*
 * UART transmitter. Serializes one byte as a start bit, eight data bits
 * LSB first and STOP_BITS stop bits, BIT_CLKS clocks per bit.
 */
module uart_tx #(
	parameter int BIT_CLKS  = 217,
	parameter int STOP_BITS = 2
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_valid,
	output logic       byte_ready,
	output logic       uart_tx_port
);

	localparam int CNT_W = $clog2(BIT_CLKS + 1);

	uart_str_pkg::uart_state_e state;
	logic [CNT_W-1:0]          bit_cnt;     // Clocks within the current bit.
	logic [2:0]                bit_idx;     // Data bit or stop bit number.
	logic [7:0]                tx_shift;
	logic                      bit_end;
	logic                      accept;

	assign byte_ready = (state == uart_str_pkg::uart_idle);
	assign accept     = byte_valid && byte_ready;
	assign bit_end    = (bit_cnt == CNT_W'(BIT_CLKS - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state        <= uart_str_pkg::uart_idle;
			bit_cnt      <= '0;
			bit_idx      <= '0;
			uart_tx_port <= 1'b1;
		end else begin
			bit_cnt <= bit_end ? '0 : bit_cnt + CNT_W'(1);
			case (state)
			uart_str_pkg::uart_idle: begin
				bit_cnt <= '0;
				if (accept) begin
					state        <= uart_str_pkg::uart_start;
					uart_tx_port <= 1'b0;           // Start bit next cycle.
				end
			end
			uart_str_pkg::uart_start: begin
				if (bit_end) begin
					state        <= uart_str_pkg::uart_data;
					bit_idx      <= '0;
					uart_tx_port <= tx_shift[0];
				end
			end
			uart_str_pkg::uart_data: begin
				if (bit_end) begin
					if (bit_idx == 3'd7) begin
						state        <= uart_str_pkg::uart_stop;
						bit_idx      <= '0;
						uart_tx_port <= 1'b1;
					end else begin
						bit_idx      <= bit_idx + 3'd1;
						uart_tx_port <= tx_shift[1];    // Next bit before the shift.
					end
				end
			end
			uart_str_pkg::uart_stop: begin
				if (bit_end) begin
					if (bit_idx == 3'(STOP_BITS - 1))
						state <= uart_str_pkg::uart_idle;
					else
						bit_idx <= bit_idx + 3'd1;
				end
			end
			default: state <= uart_str_pkg::uart_idle;
			endcase
		end
	end

	// Byte shifter loaded on acceptance.
	always_ff @(posedge sys_clk) begin
		if (accept)
			tx_shift <= byte_data;
		else if (state == uart_str_pkg::uart_data && bit_end)
			tx_shift <= tx_shift >> 1;
	end

	a_idle_line_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(state == uart_str_pkg::uart_idle) |-> uart_tx_port);

endmodule

// File: uart_str_pkg.sv
/*
 * Shared definitions for the framed string link.
 * Holds the frame delimiter byte and the state encodings
 * of the UART bit engines, the framer and the deframer.
 */
package uart_str_pkg;

	// Delimiter byte is ASCII '&'.
	localparam logic [7:0] frame_mark = 8'h26;

	// Bit-level state shared by uart_tx and uart_rx.
	typedef enum logic [1:0] {
		uart_idle,                              // Line high and waiting.
		uart_start,                             // Start bit.
		uart_data,                              // Eight data bits, LSB first.
		uart_stop                               // Stop bit(s).
	} uart_state_e;

	// Framer steps through one frame.
	typedef enum logic [2:0] {
		fr_idle,                                // Ready for a new string.
		fr_head1,                               // First opening mark.
		fr_head2,                               // Second opening mark.
		fr_body,                                // Payload bytes.
		fr_tail1,                               // First closing mark.
		fr_tail2                                // Second closing mark, then done.
	} framer_state_e;

	// Deframer states.
	typedef enum logic [2:0] {
		df_hunt,                                // Looking for an opening mark.
		df_head2,                               // Need a second mark.
		df_body,                                // Collecting payload.
		df_mark,                                // One mark seen inside the body.
		df_drop                                 // Oversized frame, skip to its end.
	} deframer_state_e;

endpackage
